// ==== source/core101_pkg.sv ====
// ======================================================================
// core101 shared definitions: widths, RV32I opcodes and function codes,
// ALU operation codes and the instruction word layout
// ======================================================================

package core101_pkg;

  // Datapath and register index widths
  localparam int xlen       = 32;
  localparam int reg_addr_w = 5;

  // ====================================================================
  // Major opcodes accepted by the decoder
  // ====================================================================
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  // funct3 per operation, shared by R-type and I-type
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct7, base form and alternate form (sub, sra, srai)
  localparam logic [6:0] f7_base = 7'b0000000;
  localparam logic [6:0] f7_alt  = 7'b0100000;

  // ALU operations, pass_b carries LUI
  typedef enum logic [3:0] {
    alu_add    = 4'd0,
    alu_sub    = 4'd1,
    alu_sll    = 4'd2,
    alu_slt    = 4'd3,
    alu_sltu   = 4'd4,
    alu_xor    = 4'd5,
    alu_srl    = 4'd6,
    alu_sra    = 4'd7,
    alu_or     = 4'd8,
    alu_and    = 4'd9,
    alu_pass_b = 4'd10
  } alu_op_t;

  // ====================================================================
  // Instruction word, one 32-bit word seen as R, I or U format
  // ====================================================================
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [19:0] imm20;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
  } instr_t;

  // ADDI x0,x0,0
  localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

endpackage

// ==== source/fetch_unit.sv ====
// ======================================================================
// Fetch unit: program counter, instruction register and halt control
// ======================================================================

`timescale 1ns/100ps

module fetch_unit import core101_pkg::*; (
  input  logic            clock_in,
  input  logic            rst_n,
  input  logic            halt,
  input  logic [xlen-1:0] ins_data,
  output logic [xlen-1:0] ins_addr,
  output instr_t          ir,
  output logic            ir_valid
);

  // Current fetch address
  logic [xlen-1:0] pc;

  // Memory answers in the same cycle
  assign ins_addr = pc;

  // ====================================================================
  // PC and instruction register
  // ====================================================================
  always_ff @(posedge clock_in) begin
    if (!rst_n) begin
      pc       <= '0;
      ir       <= nop_word;
      ir_valid <= 1'b0;
    end else if (halt) begin
      // PC holds, bubble goes down the pipe
      ir_valid <= 1'b0;
    end else begin
      ir       <= ins_data;
      ir_valid <= 1'b1;
      // Sequential flow only, no branches
      pc       <= pc + xlen'(4);
    end
  end

  // Word at the held PC is taken once halt drops,
  // so nothing is skipped or fetched twice

endmodule

// ==== source/decode_unit.sv ====
// ======================================================================
// Decode unit: instruction word to ALU operation, register indices
// and immediate; purely combinational
// ======================================================================

`timescale 1ns/100ps

module decode_unit import core101_pkg::*; (
  input  instr_t                ir,
  input  logic                  ir_valid,
  output logic                  dec_valid,
  output logic                  dec_illegal,
  output alu_op_t               alu_op,
  output logic [reg_addr_w-1:0] rs1,
  output logic [reg_addr_w-1:0] rs2,
  output logic [reg_addr_w-1:0] rd,
  output logic [xlen-1:0]       imm,
  output logic                  use_imm,
  output logic                  writes_rd
);

  // Word is malformed
  logic bad;
  // funct7 is base or alternate
  logic f7_ok;
  // Alternate funct7 in R view
  logic r_alt;
  // Alternate funct7 in upper bits of imm12
  logic i_alt;
  // I-type funct3 is a shift
  logic i_shift;

  assign f7_ok   = (ir.r.funct7 == f7_base) || (ir.r.funct7 == f7_alt);
  assign r_alt   = (ir.r.funct7 == f7_alt);
  assign i_alt   = (ir.i.imm12[11:5] == f7_alt);
  assign i_shift = (ir.i.funct3 == f3_sll) || (ir.i.funct3 == f3_srl_sra);

  // Register fields sit at the same bits in every format
  assign rs1 = ir.r.rs1;
  assign rs2 = ir.r.rs2;
  assign rd  = ir.u.rd;

  // Only rd test in the core, x0 writes are dropped
  assign writes_rd = (rd != '0);

  // funct3 to ALU op, alt picks sub or sra
  function automatic alu_op_t funct_to_op(input logic [2:0] f3,
                                          input logic alt_sub,
                                          input logic alt_sra);
    case (f3)
      f3_add_sub: funct_to_op = alt_sub ? alu_sub : alu_add;
      f3_sll:     funct_to_op = alu_sll;
      f3_slt:     funct_to_op = alu_slt;
      f3_sltu:    funct_to_op = alu_sltu;
      f3_xor:     funct_to_op = alu_xor;
      f3_srl_sra: funct_to_op = alt_sra ? alu_sra : alu_srl;
      f3_or:      funct_to_op = alu_or;
      default:    funct_to_op = alu_and;
    endcase
  endfunction

  // ====================================================================
  // Format select and operation mapping
  // ====================================================================
  always_comb begin
    bad     = 1'b0;
    alu_op  = alu_add;
    imm     = '0;
    use_imm = 1'b0;
    case (ir.r.opcode)
      opc_op: begin
        // Register-register, funct7 decides sub and sra
        alu_op = funct_to_op(ir.r.funct3, r_alt, r_alt);
        bad    = !f7_ok;
      end
      opc_op_imm: begin
        use_imm = 1'b1;
        // No subi, so alt only marks srai
        alu_op  = funct_to_op(ir.i.funct3, 1'b0, i_alt);
        if (i_shift) begin
          // Shift amount in low imm bits
          imm = {{(xlen-5){1'b0}}, ir.i.imm12[4:0]};
          bad = !f7_ok;
        end else begin
          imm = {{(xlen-12){ir.i.imm12[11]}}, ir.i.imm12};
        end
      end
      opc_lui: begin
        use_imm = 1'b1;
        alu_op  = alu_pass_b;
        imm     = {ir.u.imm20, 12'b0};
      end
      default: bad = 1'b1;
    endcase
  end

  assign dec_valid   = ir_valid && !bad;
  assign dec_illegal = ir_valid && bad;

endmodule

// ==== source/issue_stage.sv ====
// ======================================================================
// Issue stage: register file read, single-level bypass and operand
// pipeline register
// ======================================================================

`timescale 1ns/100ps

module issue_stage import core101_pkg::*; (
  input  logic                  clock_in,
  input  logic                  rst_n,
  input  logic                  dec_valid,
  input  logic                  dec_illegal,
  input  alu_op_t               alu_op,
  input  logic [reg_addr_w-1:0] rs1,
  input  logic [reg_addr_w-1:0] rs2,
  input  logic [reg_addr_w-1:0] rd,
  input  logic [xlen-1:0]       imm,
  input  logic                  use_imm,
  input  logic                  writes_rd,
  input  logic [xlen-1:0]       rs1_data,
  input  logic [xlen-1:0]       rs2_data,
  input  logic                  fwd_valid,
  input  logic [reg_addr_w-1:0] fwd_rd,
  input  logic [xlen-1:0]       fwd_data,
  output logic [reg_addr_w-1:0] rf_rs1,
  output logic [reg_addr_w-1:0] rf_rs2,
  output logic                  iss_valid,
  output logic                  iss_illegal,
  output alu_op_t               iss_op,
  output logic [xlen-1:0]       iss_a,
  output logic [xlen-1:0]       iss_b,
  output logic [reg_addr_w-1:0] iss_rd
);

  // Operands after bypass
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;

  // Register file read ports
  assign rf_rs1 = rs1;
  assign rf_rs2 = rs2;

  // Result still in execute wins over the stale register
  // fwd_valid is never set for x0
  assign op_a = (fwd_valid && (fwd_rd == rs1)) ? fwd_data : rs1_data;
  assign op_b = use_imm ? imm :
                (fwd_valid && (fwd_rd == rs2)) ? fwd_data : rs2_data;

  // ====================================================================
  // Issue register
  // ====================================================================
  always_ff @(posedge clock_in) begin
    if (!rst_n) begin
      iss_valid   <= 1'b0;
      iss_illegal <= 1'b0;
    end else begin
      // x0 target issues as a bubble
      iss_valid   <= dec_valid && writes_rd;
      iss_illegal <= dec_illegal;
    end
  end

  // Payload
  always_ff @(posedge clock_in) begin
    iss_op <= alu_op;
    iss_a  <= op_a;
    iss_b  <= op_b;
    iss_rd <= rd;
  end

endmodule

// ==== source/register_file.sv ====
// ======================================================================
// General purpose registers: 32 x 32-bit, two read ports, one write
// port, x0 reads as zero
// ======================================================================

`timescale 1ns/100ps

module register_file import core101_pkg::*; (
  input  logic                  clock_in,
  input  logic                  rst_n,
  input  logic [reg_addr_w-1:0] rf_rs1,
  input  logic [reg_addr_w-1:0] rf_rs2,
  output logic [xlen-1:0]       rs1_data,
  output logic [xlen-1:0]       rs2_data,
  input  logic                  we,
  input  logic [reg_addr_w-1:0] waddr,
  input  logic [xlen-1:0]       wdata
);

  logic [xlen-1:0] regs [2**reg_addr_w];

  // Clear all on reset, else one write per cycle
  always_ff @(posedge clock_in) begin
    if (!rst_n) begin
      for (int k = 0; k < 2**reg_addr_w; k++) begin
        regs[k] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Asynchronous reads, x0 hard zero
  assign rs1_data = (rf_rs1 == '0) ? '0 : regs[rf_rs1];
  assign rs2_data = (rf_rs2 == '0) ? '0 : regs[rf_rs2];

endmodule

// ==== source/int_exec_unit.sv ====
// ======================================================================
// Integer execution unit: ALU, bypass source and registered writeback
// ======================================================================

`timescale 1ns/100ps

module int_exec_unit import core101_pkg::*; (
  input  logic                  clock_in,
  input  logic                  rst_n,
  input  logic                  iss_valid,
  input  logic                  iss_illegal,
  input  alu_op_t               iss_op,
  input  logic [xlen-1:0]       iss_a,
  input  logic [xlen-1:0]       iss_b,
  input  logic [reg_addr_w-1:0] iss_rd,
  output logic                  fwd_valid,
  output logic [reg_addr_w-1:0] fwd_rd,
  output logic [xlen-1:0]       fwd_data,
  output logic                  wb_valid,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data,
  output logic                  illegal_instr
);

  // Shift amount, low 5 bits of b
  logic [4:0] shamt;

  assign shamt = iss_b[4:0];

  // ====================================================================
  // ALU
  // ====================================================================
  always_comb begin
    case (iss_op)
      alu_add:    fwd_data = iss_a + iss_b;
      alu_sub:    fwd_data = iss_a - iss_b;
      alu_sll:    fwd_data = iss_a << shamt;
      alu_slt:    fwd_data = {{(xlen-1){1'b0}}, $signed(iss_a) < $signed(iss_b)};
      alu_sltu:   fwd_data = {{(xlen-1){1'b0}}, iss_a < iss_b};
      alu_xor:    fwd_data = iss_a ^ iss_b;
      alu_srl:    fwd_data = iss_a >> shamt;
      // Sign fill from bit 31
      alu_sra:    fwd_data = $unsigned($signed(iss_a) >>> shamt);
      alu_or:     fwd_data = iss_a | iss_b;
      alu_and:    fwd_data = iss_a & iss_b;
      alu_pass_b: fwd_data = iss_b;
      default:    fwd_data = '0;
    endcase
  end

  // Bypass and register file write, rd test already folded in
  assign fwd_valid = iss_valid;
  assign fwd_rd    = iss_rd;

  // ====================================================================
  // Writeback port
  // ====================================================================
  always_ff @(posedge clock_in) begin
    if (!rst_n) begin
      wb_valid      <= 1'b0;
      illegal_instr <= 1'b0;
    end else begin
      wb_valid      <= iss_valid;
      illegal_instr <= iss_illegal;
    end
  end

  // Payload, qualified by wb_valid
  always_ff @(posedge clock_in) begin
    wb_rd   <= iss_rd;
    wb_data <= fwd_data;
  end

endmodule

// ==== source/core101_top.sv ====
// ======================================================================
// core101 top: fetch, decode, issue, register file and integer execute
// wired into a three-stage in-order pipeline
// ======================================================================

`timescale 1ns/100ps

module core101_top import core101_pkg::*; (
  // Clock and reset
  input  logic                  clock_in,
  input  logic                  rst_n,

  // Fetch pause
  input  logic                  halt,

  // Instruction memory, outside the core
  input  logic [xlen-1:0]       ins_data,
  output logic [xlen-1:0]       ins_addr,

  // Writeback observation
  output logic                  wb_valid,
  output logic [reg_addr_w-1:0] wb_rd,
  output logic [xlen-1:0]       wb_data,
  output logic                  illegal_instr
);

  // Fetch to decode
  instr_t                ir;
  logic                  ir_valid;

  // Decode to issue
  logic                  dec_valid;
  logic                  dec_illegal;
  alu_op_t               alu_op;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [reg_addr_w-1:0] rd;
  logic [xlen-1:0]       imm;
  logic                  use_imm;
  logic                  writes_rd;

  // Register file read
  logic [reg_addr_w-1:0] rf_rs1;
  logic [reg_addr_w-1:0] rf_rs2;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  // Issue to execute
  logic                  iss_valid;
  logic                  iss_illegal;
  alu_op_t               iss_op;
  logic [xlen-1:0]       iss_a;
  logic [xlen-1:0]       iss_b;
  logic [reg_addr_w-1:0] iss_rd;

  // Execute result, bypass and register write
  logic                  fwd_valid;
  logic [reg_addr_w-1:0] fwd_rd;
  logic [xlen-1:0]       fwd_data;

  // ====================================================================
  // Pipeline blocks
  // ====================================================================
  fetch_unit fetch0 (
    .clock_in, .rst_n, .halt, .ins_data, .ins_addr, .ir, .ir_valid
  );

  decode_unit decode0 (
    .ir, .ir_valid, .dec_valid, .dec_illegal, .alu_op,
    .rs1, .rs2, .rd, .imm, .use_imm, .writes_rd
  );

  issue_stage issue0 (
    .clock_in, .rst_n, .dec_valid, .dec_illegal, .alu_op,
    .rs1, .rs2, .rd, .imm, .use_imm, .writes_rd,
    .rs1_data, .rs2_data, .fwd_valid, .fwd_rd, .fwd_data,
    .rf_rs1, .rf_rs2, .iss_valid, .iss_illegal, .iss_op,
    .iss_a, .iss_b, .iss_rd
  );

  // Written from the execute result at the writeback edge
  register_file rf0 (
    .clock_in, .rst_n, .rf_rs1, .rf_rs2, .rs1_data, .rs2_data,
    .we(fwd_valid), .waddr(fwd_rd), .wdata(fwd_data)
  );

  int_exec_unit int0 (
    .clock_in, .rst_n, .iss_valid, .iss_illegal, .iss_op,
    .iss_a, .iss_b, .iss_rd, .fwd_valid, .fwd_rd, .fwd_data,
    .wb_valid, .wb_rd, .wb_data, .illegal_instr
  );

endmodule

// ==== dv/core101_assertions.sv ====
// ======================================================================
// core101 protocol checks: reset state, writeback pulse rules and
// fetch address hold during halt
// ======================================================================

`timescale 1ns/100ps

module core101_assertions import core101_pkg::*; (
  input logic            clock_in,
  input logic            rst_n,
  input logic            halt,
  input logic [xlen-1:0] ins_addr,
  input logic            wb_valid,
  input logic            illegal_instr
);

  // Outputs come out of reset low
  reset_clears_outputs: assert property (@(posedge clock_in)
    !rst_n |=> (!wb_valid && !illegal_instr))
    else $error("wb_valid or illegal_instr high right after reset");

  // One retire kind per cycle
  retire_kinds_exclusive: assert property (@(posedge clock_in) disable iff (!rst_n)
    !(wb_valid && illegal_instr))
    else $error("wb_valid and illegal_instr high in the same cycle");

  // PC frozen while fetch is paused
  halt_holds_address: assert property (@(posedge clock_in) disable iff (!rst_n)
    halt |=> $stable(ins_addr))
    else $error("ins_addr moved while halt was high");

endmodule

bind core101_top core101_assertions asrt0 (.*);

// ==== dv/core101_tb.sv ====
// ======================================================================
// core101 testbench: random program memory, reference model of the
// integer ISA subset, in-order retire checker and watchdog
// ======================================================================

`timescale 1ns/100ps

module core101_tb import core101_pkg::*;;

  localparam int prog_len = 200;

  logic                  clock_in = 1'b0;
  logic                  rst_n;
  logic                  halt;
  logic [xlen-1:0]       ins_data;
  logic [xlen-1:0]       ins_addr;
  logic                  wb_valid;
  logic [reg_addr_w-1:0] wb_rd;
  logic [xlen-1:0]       wb_data;
  logic                  illegal_instr;

  // Program memory and model state
  logic [31:0] prog [256];
  logic [31:0] model_regs [32];
  // Record: illegal, valid, rd, data
  logic [38:0] exp_q [$];
  integer      seed = 32'hc60a;
  int          edges = 0;
  logic        fetch_done = 1'b0;

  core101_top dut0 (
    .clock_in, .rst_n, .halt, .ins_data, .ins_addr,
    .wb_valid, .wb_rd, .wb_data, .illegal_instr
  );

  always #4 clock_in = ~clock_in;

  // Memory answers in the same cycle
  assign ins_data = prog[ins_addr[9:2]];

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Test failures found");
    $fatal(1);
  endtask

  // ====================================================================
  // Reference model, one instruction per call
  // ====================================================================
  function automatic logic [38:0] model_instr(input logic [31:0] w,
                                              input logic [31:0] regs [32]);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic        alt;
    logic        illegal;
    opc     = w[6:0];
    f3      = w[14:12];
    f7      = w[31:25];
    rd      = w[11:7];
    a       = regs[w[19:15]];
    b       = regs[w[24:20]];
    alt     = (f7 == 7'h20);
    illegal = 1'b0;
    res     = 32'h0;
    if (opc == 7'h13) begin
      if (f3 == 3'd1 || f3 == 3'd5) begin
        // Shift amount sits in rs2 bits
        illegal = !(f7 == 7'h00 || alt);
        b       = {27'h0, w[24:20]};
      end else begin
        b = {{20{w[31]}}, w[31:20]};
      end
      // No subtract immediate
      alt = alt && (f3 == 3'd5);
    end else if (opc == 7'h33) begin
      illegal = !(f7 == 7'h00 || alt);
    end else if (opc != 7'h37) begin
      illegal = 1'b1;
    end
    if (opc == 7'h37) begin
      res = {w[31:12], 12'h0};
    end else begin
      case (f3)
        3'd0: res = alt ? a - b : a + b;
        3'd1: res = a << b[4:0];
        3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: res = (a < b) ? 32'd1 : 32'd0;
        3'd4: res = a ^ b;
        3'd5: begin
          // Arithmetic form fills with bit 31
          if (alt) begin
            res = $signed(a) >>> b[4:0];
          end else begin
            res = a >> b[4:0];
          end
        end
        3'd6: res = a | b;
        3'd7: res = a & b;
      endcase
    end
    return {illegal, !illegal && (rd != 5'd0), rd, res};
  endfunction

  // Random program over x0..x7, so dependencies are frequent
  task automatic build_program();
    logic [31:0] rnd;
    logic [31:0] rimm;
    logic [31:0] w;
    logic [38:0] rec;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    for (int n = 0; n < 32; n++) begin
      model_regs[n] = 32'h0;
    end
    for (int n = 0; n < 256; n++) begin
      // Pad as ADDI x0,x0,index, which retires nothing
      prog[n] = {n[11:0], 13'h0, 7'h13};
    end
    for (int n = 0; n < prog_len; n++) begin
      rnd  = $random(seed);
      rimm = $random(seed);
      rd   = {2'b00, rnd[6:4]};
      rs1  = {2'b00, rnd[9:7]};
      rs2  = {2'b00, rnd[12:10]};
      f3   = rnd[15:13];
      // Alternate form only where it has a meaning
      f7   = (rnd[16] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
      if (rnd[3:0] <= 4'd6) begin
        w = {f7, rs2, rs1, f3, rd, 7'h33};
      end else if (rnd[3:0] <= 4'd10) begin
        if (f3 == 3'd1 || f3 == 3'd5) begin
          w = {(f3 == 3'd5) ? f7 : 7'h00, rimm[4:0], rs1, f3, rd, 7'h13};
        end else begin
          w = {rimm[11:0], rs1, f3, rd, 7'h13};
        end
      end else if (rnd[3:0] <= 4'd12) begin
        w = {rimm[31:12], rd, 7'h37};
      end else if (rnd[3:0] == 4'd13) begin
        // Load or branch opcode, both unsupported
        w = {rimm[31:7], rnd[16] ? 7'h03 : 7'h63};
      end else if (rnd[3:0] == 4'd14) begin
        w = {rimm[6:1], 1'b1, rs2, rs1, f3, rd, 7'h33};
      end else begin
        w = {rimm[6:1], 1'b1, rs2, rs1, rnd[16] ? 3'd1 : 3'd5, rd, 7'h13};
      end
      prog[n] = w;
      rec = model_instr(w, model_regs);
      if (rec[37]) begin
        model_regs[rec[36:32]] = rec[31:0];
      end
      if (rec[38] || rec[37]) begin
        exp_q.push_back(rec);
      end
    end
  endtask

  // Random pauses, then a permanent halt past the program end
  always @(posedge clock_in) begin : halt_drive
    logic [31:0] rnd;
    #1;
    rnd = $random(seed);
    halt = fetch_done || (rnd[1:0] == 2'b00);
  end

  // Edges since reset release, first retire is 3 edges out
  always @(posedge clock_in) begin
    if (!rst_n) begin
      edges <= 0;
    end else begin
      edges <= edges + 1;
    end
  end

  task automatic check_retire(input logic [38:0] exp_rec);
    assert (illegal_instr == exp_rec[38])
      else abort_run($sformatf("Fail illegal_instr: got %h expected %h",
                               illegal_instr, exp_rec[38]));
    assert (wb_valid == exp_rec[37])
      else abort_run($sformatf("Fail wb_valid: got %h expected %h",
                               wb_valid, exp_rec[37]));
    if (exp_rec[37]) begin
      assert (wb_rd == exp_rec[36:32])
        else abort_run($sformatf("Fail wb_rd: got %h expected %h", wb_rd, exp_rec[36:32]));
      assert (wb_data == exp_rec[31:0])
        else abort_run($sformatf("Fail wb_data: got %h expected %h", wb_data, exp_rec[31:0]));
    end
  endtask

  // ====================================================================
  // Compare, one record per retire pulse, sampled mid-cycle
  // ====================================================================
  always @(negedge clock_in) begin : compare
    if (rst_n && (wb_valid || illegal_instr)) begin
      assert (edges >= 3)
        else abort_run("A retire pulse came before the first instruction could get there");
      assert (exp_q.size() != 0)
        else abort_run("A retire pulse came with no instruction left to retire");
      check_retire(exp_q.pop_front());
    end
  end

  initial begin : watchdog
    repeat (prog_len * 12 + 200) @(posedge clock_in);
    abort_run("Timeout: the program did not finish retiring in time");
  end

  initial begin
    rst_n = 1'b0;
    halt  = 1'b0;
    build_program();
    repeat (8) @(posedge clock_in);
    #1;
    assert (ins_addr == 32'h0)
      else abort_run($sformatf("Fail ins_addr: got %h expected %h", ins_addr, 32'h0));
    rst_n = 1'b1;
    // Last program word is in the instruction register
    wait (ins_addr >= xlen'(prog_len * 4));
    fetch_done = 1'b1;
    // Pipeline drains in 3 edges, nothing more may retire from the padding
    repeat (16) @(posedge clock_in);
    if (exp_q.size() == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run("Some program instructions never retired");
    end
  end

endmodule

// ==== core101.f ====
source/core101_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/issue_stage.sv
source/register_file.sv
source/int_exec_unit.sv
source/core101_top.sv
dv/core101_assertions.sv
dv/core101_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the core101 testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module core101_tb -f core101.f -o core101_sim

# Simulator status is not trusted, the printed verdict is
output=$(./obj_dir/core101_sim 2>&1 || true)
echo "$output"

if echo "$output" | grep -q 'All tests passed!'; then
  exit 0
fi
exit 1
